// File: common/bus_pkg.sv
package bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and limits
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  localparam int unsigned ByteOffW       = $clog2(StrbWidth);
  localparam int unsigned MaxOutstanding = 4;  // depth of every routing queue.

  typedef logic [AddrWidth-1:0]                addr_t;
  typedef logic [DataWidth-1:0]                data_t;
  typedef logic [StrbWidth-1:0]                strb_t;
  typedef logic [$clog2(MaxOutstanding+1)-1:0] cnt_t;   // outstanding responses.
  typedef logic [$clog2(MaxOutstanding)-1:0]   qptr_t;  // routing queue slot.

  //////////////////////////////////////////////////////////////////////
  // req/gnt link with separate r_valid response
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  req;
    addr_t addr;
    logic  we;     // active high write.
    strb_t be;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_rdata;
  } bus_rsp_t;

endpackage

// File: common/cluster_map_pkg.sv
package cluster_map_pkg;

  import bus_pkg::*;

  localparam int unsigned NumCores     = 2;
  localparam addr_t       TcdmBase     = 32'h1000_0000;
  localparam int unsigned TcdmWords    = 1024;  // 4 KiB window.
  localparam int unsigned TcdmIdxW     = 10;
  localparam addr_t       TcdmEnd      = TcdmBase + addr_t'(TcdmWords * StrbWidth);
  localparam int unsigned PeriphSelBit = 11;    // clear: event unit, set: dma control.

  typedef logic [TcdmIdxW-1:0]         tcdm_idx_t;
  typedef logic [$clog2(NumCores)-1:0] core_idx_t;

  typedef struct packed {
    logic periph_ld;
    logic periph_st;
    logic periph_stall;
  } perf_evt_t;

endpackage

// File: core_demux/core_demux.sv
`timescale 1ns/1ps

module core_demux import bus_pkg::*, cluster_map_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  bus_req_t  core_req_i,
  output bus_rsp_t  core_rsp_o,
  output bus_req_t  tcdm_req_o,
  input  bus_rsp_t  tcdm_rsp_i,
  output bus_req_t  periph_req_o,
  input  bus_rsp_t  periph_rsp_i,
  output perf_evt_t perf_o
);

  logic      is_tcdm;
  logic      hold;
  logic      tcdm_xfer;
  logic      periph_xfer;
  cnt_t      cnt_q;
  logic      periph_q;  // side that owes the pending responses.
  perf_evt_t perf_q;

  assign is_tcdm = (core_req_i.addr >= TcdmBase) && (core_req_i.addr < TcdmEnd);

  // switching sides must wait until the old side has drained.
  assign hold = ((cnt_q != '0) && (is_tcdm == periph_q)) ||
                (cnt_q == cnt_t'(MaxOutstanding));

  //////////////////////////////////////////////////////////////////////
  // request routing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    tcdm_req_o       = core_req_i;
    periph_req_o     = core_req_i;
    tcdm_req_o.req   = core_req_i.req && is_tcdm && !hold;
    periph_req_o.req = core_req_i.req && !is_tcdm && !hold;
  end

  assign tcdm_xfer   = tcdm_req_o.req && tcdm_rsp_i.gnt;
  assign periph_xfer = periph_req_o.req && periph_rsp_i.gnt;

  assign core_rsp_o.gnt     = tcdm_xfer || periph_xfer;
  assign core_rsp_o.r_valid = periph_q ? periph_rsp_i.r_valid : tcdm_rsp_i.r_valid;
  assign core_rsp_o.r_rdata = periph_q ? periph_rsp_i.r_rdata : tcdm_rsp_i.r_rdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q    <= '0;
      periph_q <= 1'b0;
    end else begin
      case ({core_rsp_o.gnt, core_rsp_o.r_valid})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
      if (core_rsp_o.gnt) periph_q <= periph_xfer;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // performance events
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      perf_q <= '0;
    end else begin
      perf_q.periph_ld    <= periph_xfer && !core_req_i.we;
      perf_q.periph_st    <= periph_xfer && core_req_i.we;
      perf_q.periph_stall <= core_req_i.req && !is_tcdm && !core_rsp_o.gnt;
    end
  end

  assign perf_o = perf_q;

  // the core keeps a waiting request unchanged up to its grant.
  assert property (@(posedge clk_i) disable iff (reset_i)
    core_req_i.req && !core_rsp_o.gnt |=> core_req_i.req && $stable(core_req_i))
    else $error("core request changed before grant");

endmodule

// File: core_demux/periph_demux.sv
`timescale 1ns/1ps

module periph_demux import bus_pkg::*, cluster_map_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  bus_req_t periph_req_i,
  output bus_rsp_t periph_rsp_o,
  output bus_req_t eu_req_o,
  input  bus_rsp_t eu_rsp_i,
  output bus_req_t dma_req_o,
  input  bus_rsp_t dma_rsp_i
);

  logic sel_dma;
  logic hold;
  logic eu_xfer;
  logic dma_xfer;
  cnt_t cnt_q;
  logic dma_q;  // target of the pending responses.

  assign sel_dma = periph_req_i.addr[PeriphSelBit];

  assign hold = ((cnt_q != '0) && (sel_dma != dma_q)) ||
                (cnt_q == cnt_t'(MaxOutstanding));

  always_comb begin
    eu_req_o      = periph_req_i;
    dma_req_o     = periph_req_i;
    eu_req_o.req  = periph_req_i.req && !sel_dma && !hold;
    dma_req_o.req = periph_req_i.req && sel_dma && !hold;
  end

  assign eu_xfer  = eu_req_o.req && eu_rsp_i.gnt;
  assign dma_xfer = dma_req_o.req && dma_rsp_i.gnt;

  assign periph_rsp_o.gnt     = eu_xfer || dma_xfer;
  assign periph_rsp_o.r_valid = dma_q ? dma_rsp_i.r_valid : eu_rsp_i.r_valid;
  assign periph_rsp_o.r_rdata = dma_q ? dma_rsp_i.r_rdata : eu_rsp_i.r_rdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
      dma_q <= 1'b0;
    end else begin
      case ({periph_rsp_o.gnt, periph_rsp_o.r_valid})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
      if (periph_rsp_o.gnt) dma_q <= dma_xfer;
    end
  end

  // a response only comes from the port that owes one.
  assert property (@(posedge clk_i) disable iff (reset_i)
    eu_rsp_i.r_valid |-> (cnt_q != '0) && !dma_q)
    else $error("event unit response with none pending");

  assert property (@(posedge clk_i) disable iff (reset_i)
    dma_rsp_i.r_valid |-> (cnt_q != '0) && dma_q)
    else $error("dma control response with none pending");

endmodule

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*, cluster_map_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  bus_req_t mst_req_i [NumCores],
  output bus_rsp_t mst_rsp_o [NumCores],
  output bus_req_t slv_req_o,
  input  bus_rsp_t slv_rsp_i
);

  core_idx_t               rr_q;   // highest priority master.
  core_idx_t               win_idx;
  logic                    win_valid;
  logic                    full;
  logic                    xfer;
  logic [NumCores-1:0]     gnt_vec;
  core_idx_t               q_mem [MaxOutstanding];
  qptr_t                   wr_ptr_q;
  qptr_t                   rd_ptr_q;
  cnt_t                    cnt_q;

  always_comb begin
    win_valid = 1'b0;
    win_idx   = rr_q;
    for (int unsigned i = 0; i < NumCores; i++) begin
      if (!win_valid && mst_req_i[(rr_q + i) % NumCores].req) begin
        win_valid = 1'b1;
        win_idx   = core_idx_t'((rr_q + i) % NumCores);
      end
    end
  end

  assign full = (cnt_q == cnt_t'(MaxOutstanding));

  always_comb begin
    slv_req_o     = mst_req_i[win_idx];
    slv_req_o.req = win_valid && !full;
  end

  assign xfer = slv_req_o.req && slv_rsp_i.gnt;

  always_comb begin
    for (int unsigned i = 0; i < NumCores; i++) begin
      gnt_vec[i]           = xfer && (win_idx == core_idx_t'(i));
      mst_rsp_o[i].gnt     = gnt_vec[i];
      mst_rsp_o[i].r_valid = slv_rsp_i.r_valid && (q_mem[rd_ptr_q] == core_idx_t'(i));
      mst_rsp_o[i].r_rdata = slv_rsp_i.r_rdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // priority pointer and response routing queue
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (xfer) q_mem[wr_ptr_q] <= win_idx;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q     <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (xfer) begin
        rr_q     <= core_idx_t'((win_idx + 1) % NumCores);  // next after winner.
        wr_ptr_q <= qptr_t'((wr_ptr_q + 1) % MaxOutstanding);
      end
      if (slv_rsp_i.r_valid) rd_ptr_q <= qptr_t'((rd_ptr_q + 1) % MaxOutstanding);
      case ({xfer, slv_rsp_i.r_valid})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // every slave response pops a queued winner.
  assert property (@(posedge clk_i) disable iff (reset_i) slv_rsp_i.r_valid |-> (cnt_q != '0))
    else $error("slave response with no request pending");

endmodule

// File: src/tcdm_bank.sv
`timescale 1ns/1ps

module tcdm_bank import bus_pkg::*, cluster_map_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  data_t     mem_q [TcdmWords];
  tcdm_idx_t idx;
  data_t     rdata_q;
  logic      r_valid_q;

  assign idx = req_i.addr[ByteOffW +: TcdmIdxW];  // wraps inside the window.

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (req_i.be[b]) mem_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i.req;  // every access answers next cycle.
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = rdata_q;

endmodule

// File: src/cluster_data_path.sv
`timescale 1ns/1ps

module cluster_data_path import bus_pkg::*, cluster_map_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  bus_req_t  core_req_i [NumCores],
  output bus_rsp_t  core_rsp_o [NumCores],
  output bus_req_t  eu_req_o,
  input  bus_rsp_t  eu_rsp_i,
  output bus_req_t  dma_req_o,
  input  bus_rsp_t  dma_rsp_i,
  output perf_evt_t perf_o [NumCores]
);

  bus_req_t tcdm_req   [NumCores];
  bus_rsp_t tcdm_rsp   [NumCores];
  bus_req_t periph_req [NumCores];
  bus_rsp_t periph_rsp [NumCores];
  bus_req_t bank_req;
  bus_rsp_t bank_rsp;
  bus_req_t pdemux_req;
  bus_rsp_t pdemux_rsp;

  //////////////////////////////////////////////////////////////////////
  // per core address split
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumCores; i++) begin : gen_core
    core_demux core_demux_i (
      .clk_i        ( clk_i         ),
      .reset_i      ( reset_i       ),
      .core_req_i   ( core_req_i[i] ),
      .core_rsp_o   ( core_rsp_o[i] ),
      .tcdm_req_o   ( tcdm_req[i]   ),
      .tcdm_rsp_i   ( tcdm_rsp[i]   ),
      .periph_req_o ( periph_req[i] ),
      .periph_rsp_i ( periph_rsp[i] ),
      .perf_o       ( perf_o[i]     )
    );
  end

  //////////////////////////////////////////////////////////////////////
  // shared targets
  //////////////////////////////////////////////////////////////////////

  bus_arbiter tcdm_arb (
    .clk_i     ( clk_i    ),
    .reset_i   ( reset_i  ),
    .mst_req_i ( tcdm_req ),
    .mst_rsp_o ( tcdm_rsp ),
    .slv_req_o ( bank_req ),
    .slv_rsp_i ( bank_rsp )
  );

  tcdm_bank tcdm_bank_i (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .req_i   ( bank_req ),
    .rsp_o   ( bank_rsp )
  );

  bus_arbiter periph_arb (
    .clk_i     ( clk_i      ),
    .reset_i   ( reset_i    ),
    .mst_req_i ( periph_req ),
    .mst_rsp_o ( periph_rsp ),
    .slv_req_o ( pdemux_req ),
    .slv_rsp_i ( pdemux_rsp )
  );

  periph_demux periph_demux_i (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .periph_req_i ( pdemux_req ),
    .periph_rsp_o ( pdemux_rsp ),
    .eu_req_o     ( eu_req_o   ),
    .eu_rsp_i     ( eu_rsp_i   ),
    .dma_req_o    ( dma_req_o  ),
    .dma_rsp_i    ( dma_rsp_i  )
  );

endmodule

// File: bench/tb_cluster_data_path.sv
`timescale 1ns/1ps

module tb_cluster_data_path import bus_pkg::*, cluster_map_pkg::*; ();

  localparam int unsigned CycleLimit = 4000;
  localparam addr_t       EuBase     = 32'h2000_0000;
  localparam addr_t       DmaBase    = 32'h2000_0800;

  logic      clk_i = 1'b0;
  logic      reset_i = 1'b1;
  bus_req_t  core_req [NumCores];
  bus_rsp_t  core_rsp [NumCores];
  bus_req_t  slv_req [2];  // 0: event unit, 1: dma control.
  bus_rsp_t  slv_rsp [2];
  perf_evt_t perf [NumCores];

  int          err_cnt = 0;
  int          cycle_cnt = 0;
  logic [15:0] lfsr_q = 16'd13;
  int          ld_cnt [NumCores];
  int          st_cnt [NumCores];
  int          stall_cnt [NumCores];
  int          model_stall = 0;
  data_t       model_mem [1024];
  int          gnt_wait [2];
  int          due_mem [2][16];
  data_t       dat_mem [2][16];
  int          head [2];
  int          tail [2];
  logic        xfer_seen [2];
  int          last_port;
  bus_req_t    last_req;
  addr_t       burst_addr [NumCores][16];
  logic        burst_we [NumCores][16];
  data_t       burst_wdata [NumCores][16];
  data_t       burst_rdata [NumCores][16];
  int          burst_wait [NumCores];  // longest grant wait of the last burst.

  cluster_data_path cluster_data_path_i (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .core_req_i ( core_req   ),
    .core_rsp_o ( core_rsp   ),
    .eu_req_o   ( slv_req[0] ),
    .eu_rsp_i   ( slv_rsp[0] ),
    .dma_req_o  ( slv_req[1] ),
    .dma_rsp_i  ( slv_rsp[1] ),
    .perf_o     ( perf       )
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("run stopped: cycle limit of %0d reached before the tests finished", CycleLimit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic data_t fill_word(int idx);
    return 32'hA500_0000 ^ (idx * 32'h0001_0101);
  endfunction

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t be);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  // 16 bit fibonacci lfsr, taps 16 14 13 11, one step per bit.
  task automatic take_bits(input int n, output int v);
    logic fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = (v << 1) | fb;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // event unit and dma control models
  //////////////////////////////////////////////////////////////////////

  always begin
    int d;
    @(negedge clk_i);
    for (int p = 0; p < 2; p++) begin
      xfer_seen[p] = slv_req[p].req && slv_rsp[p].gnt;
      if (slv_req[p].req && !slv_rsp[p].gnt) model_stall++;
      if (xfer_seen[p]) begin
        last_port = p;
        last_req  = slv_req[p];
        if (slv_req[p].we) begin
          model_mem[slv_req[p].addr[11:2]] =
            merge_bytes(model_mem[slv_req[p].addr[11:2]], slv_req[p].wdata, slv_req[p].be);
        end
        take_bits(2, d);
        due_mem[p][tail[p]] = cycle_cnt + 1 + d;
        dat_mem[p][tail[p]] = slv_req[p].we ? '0 : model_mem[slv_req[p].addr[11:2]];
        tail[p] = (tail[p] + 1) % 16;
      end
    end
    for (int c = 0; c < NumCores; c++) begin
      ld_cnt[c]    += perf[c].periph_ld;
      st_cnt[c]    += perf[c].periph_st;
      stall_cnt[c] += perf[c].periph_stall;
    end
    @(posedge clk_i);
    #5;
    for (int p = 0; p < 2; p++) begin
      slv_rsp[p].r_valid = 1'b0;
      if (head[p] != tail[p] && due_mem[p][head[p]] <= cycle_cnt) begin
        slv_rsp[p].r_valid = 1'b1;
        slv_rsp[p].r_rdata = dat_mem[p][head[p]];
        head[p] = (head[p] + 1) % 16;
      end
      if (xfer_seen[p]) take_bits(2, gnt_wait[p]);  // hold gnt low 0 to 3 cycles.
      if (gnt_wait[p] > 0) begin
        gnt_wait[p]--;
        slv_rsp[p].gnt = 1'b0;
      end else begin
        slv_rsp[p].gnt = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // core side access and tests
  //////////////////////////////////////////////////////////////////////

  task automatic access(input int c, input addr_t a, input logic we, input strb_t be,
                        input data_t wd, output data_t rd, output int waits, output int lat);
    @(posedge clk_i);
    #5;
    core_req[c] = '{req: 1'b1, addr: a, we: we, be: be, wdata: wd};
    waits = 0;
    @(negedge clk_i);
    while (!core_rsp[c].gnt) begin
      waits++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #5;
    core_req[c].req = 1'b0;
    lat = 1;
    @(negedge clk_i);
    while (!core_rsp[c].r_valid) begin
      lat++;
      @(negedge clk_i);
    end
    rd = core_rsp[c].r_rdata;
  endtask

  // a new request right after each grant, without waiting for responses.
  task automatic issue_burst(input int c, input int n);
    int w;
    burst_wait[c] = 0;
    for (int k = 0; k < n; k++) begin
      @(posedge clk_i);
      #5;
      core_req[c] = '{req: 1'b1, addr: burst_addr[c][k], we: burst_we[c][k], be: 4'hF,
                      wdata: burst_wdata[c][k]};
      w = 0;
      @(negedge clk_i);
      while (!core_rsp[c].gnt) begin
        w++;
        @(negedge clk_i);
      end
      if (w > burst_wait[c]) burst_wait[c] = w;
    end
    @(posedge clk_i);
    #5;
    core_req[c].req = 1'b0;
  endtask

  task automatic collect_burst(input int c, input int n);
    for (int k = 0; k < n; k++) begin
      @(negedge clk_i);
      while (!core_rsp[c].r_valid) @(negedge clk_i);
      burst_rdata[c][k] = core_rsp[c].r_rdata;
    end
  endtask

  task automatic run_burst(input int c, input int n);
    fork
      issue_burst(c, n);
      collect_burst(c, n);
    join
  endtask

  task automatic reset_outputs();
    @(negedge clk_i);
    for (int c = 0; c < NumCores; c++) begin
      check_value("core_rsp_o.gnt", 0, core_rsp[c].gnt);
      check_value("core_rsp_o.r_valid", 0, core_rsp[c].r_valid);
      check_value("perf_o", 0, perf[c]);
    end
    check_value("eu_req_o.req", 0, slv_req[0].req);
    check_value("dma_req_o.req", 0, slv_req[1].req);
  endtask

  task automatic tcdm_read_after_write();
    data_t rd;
    int    w;
    int    lat;
    access(0, TcdmBase + 32'h40, 1'b1, 4'hF, 32'hDEAD_BEEF, rd, w, lat);
    access(0, TcdmBase + 32'h40, 1'b0, 4'hF, '0, rd, w, lat);
    check_value("core_rsp_o[0].r_rdata", 32'hDEAD_BEEF, rd);
    check_value("tcdm grant wait", 0, w);
    check_value("tcdm read latency", 1, lat);
  endtask

  task automatic tcdm_byte_enable();
    data_t rd;
    int    w;
    int    lat;
    access(1, TcdmBase + 32'h80, 1'b1, 4'hF, 32'h1122_3344, rd, w, lat);
    access(1, TcdmBase + 32'h80, 1'b1, 4'b0101, 32'hAABB_CCDD, rd, w, lat);
    access(1, TcdmBase + 32'h80, 1'b0, 4'hF, '0, rd, w, lat);
    check_value("core_rsp_o[1].r_rdata",
                merge_bytes(32'h1122_3344, 32'hAABB_CCDD, 4'b0101), rd);
  endtask

  // write then read back each word, one request per cycle.
  task automatic core_stream(input int c);
    for (int k = 0; k < 16; k++) begin
      burst_addr[c][k]  = TcdmBase + addr_t'((c * 64 + k / 2) * 4);
      burst_we[c][k]    = (k % 2 == 0);
      burst_wdata[c][k] = 32'hC000_0000 | (c << 16) | (k / 2);
    end
    run_burst(c, 16);
    if (burst_wait[c] > 1) begin
      $display("core %0d waited %0d cycles for a tcdm grant", c, burst_wait[c]);
      err_cnt++;
    end
    for (int k = 1; k < 16; k += 2) begin
      check_value("core_rsp_o.r_rdata", burst_wdata[c][k - 1], burst_rdata[c][k]);
    end
  endtask

  task automatic tcdm_contention();
    fork
      core_stream(0);
      core_stream(1);
    join
  endtask

  task automatic periph_rw(input int c, input addr_t a, input logic we, input data_t d);
    data_t rd;
    int    w;
    int    lat;
    access(c, a, we, 4'hF, d, rd, w, lat);
    if (!we) check_value("periph r_rdata", d, rd);
  endtask

  // two requests to one port, the second issued right after the first grant.
  task automatic periph_pair(input int c, input addr_t a, input logic first_we, input data_t d);
    for (int k = 0; k < 2; k++) begin
      burst_addr[c][k]  = a;
      burst_we[c][k]    = first_we && (k == 0);
      burst_wdata[c][k] = d;
    end
    run_burst(c, 2);
    for (int k = 0; k < 2; k++) begin
      if (!burst_we[c][k]) check_value("periph r_rdata", d, burst_rdata[c][k]);
    end
  endtask

  task automatic periph_routing();
    data_t rd;
    int    w;
    int    lat;
    access(0, EuBase + 32'h10, 1'b1, 4'b0011, 32'h0BAD_F00D, rd, w, lat);
    check_value("target port", 0, last_port);
    check_value("eu_req_o.addr", EuBase + 32'h10, last_req.addr);
    check_value("eu_req_o.we", 1, last_req.we);
    check_value("eu_req_o.be", 4'b0011, last_req.be);
    check_value("eu_req_o.wdata", 32'h0BAD_F00D, last_req.wdata);
    access(0, DmaBase + 32'h10, 1'b1, 4'hF, 32'h1234_5678, rd, w, lat);
    check_value("target port", 1, last_port);
    check_value("dma_req_o.addr", DmaBase + 32'h10, last_req.addr);
    check_value("dma_req_o.we", 1, last_req.we);
    check_value("dma_req_o.be", 4'hF, last_req.be);
    check_value("dma_req_o.wdata", 32'h1234_5678, last_req.wdata);
    access(0, EuBase + 32'h10, 1'b0, 4'hF, '0, rd, w, lat);
    check_value("eu read data", merge_bytes(fill_word(4), 32'h0BAD_F00D, 4'b0011), rd);
    periph_rw(0, DmaBase + 32'h10, 1'b0, 32'h1234_5678);
    periph_rw(0, DmaBase + 32'h20, 1'b0, fill_word(512 + 8));  // never written.
  endtask

  task automatic perf_counters();
    int ld0;
    int st0;
    int sl0;
    int ms0;
    ld0 = ld_cnt[1];
    st0 = st_cnt[1];
    sl0 = stall_cnt[1];
    ms0 = model_stall;
    periph_pair(1, EuBase + 32'h40, 1'b1, 32'h5555_0001);
    periph_pair(1, DmaBase + 32'h40, 1'b1, 32'h5555_0002);
    periph_pair(1, EuBase + 32'h40, 1'b0, 32'h5555_0001);
    periph_rw(1, TcdmBase + 32'h100, 1'b1, 32'h7777_0000);
    periph_rw(1, TcdmBase + 32'h100, 1'b0, 32'h7777_0000);
    repeat (2) @(negedge clk_i);
    check_value("perf_o[1].periph_ld count", 4, ld_cnt[1] - ld0);
    check_value("perf_o[1].periph_st count", 2, st_cnt[1] - st0);
    check_value("perf_o[1].periph_stall count", model_stall - ms0, stall_cnt[1] - sl0);
  endtask

  task automatic mixed_core0();
    for (int k = 0; k < 6; k++) begin
      periph_rw(0, TcdmBase + 32'h200 + k * 4, 1'b1, 32'h6000_0000 + k);
      periph_rw(0, EuBase + 32'h100 + k * 4, 1'b1, 32'h6100_0000 + k);
      periph_rw(0, TcdmBase + 32'h200 + k * 4, 1'b0, 32'h6000_0000 + k);
      periph_rw(0, EuBase + 32'h100 + k * 4, 1'b0, 32'h6100_0000 + k);
    end
  endtask

  task automatic mixed_core1();
    for (int k = 0; k < 6; k++) begin
      periph_rw(1, DmaBase + 32'h100 + k * 4, 1'b1, 32'h6200_0000 + k);
      periph_rw(1, DmaBase + 32'h100 + k * 4, 1'b0, 32'h6200_0000 + k);
    end
  endtask

  task automatic mixed_traffic();
    fork
      mixed_core0();
      mixed_core1();
    join
  endtask

  initial begin
    for (int i = 0; i < 1024; i++) model_mem[i] = fill_word(i);
    for (int c = 0; c < NumCores; c++) begin
      core_req[c]   = '0;
      ld_cnt[c]     = 0;
      st_cnt[c]     = 0;
      stall_cnt[c]  = 0;
      burst_wait[c] = 0;
    end
    for (int p = 0; p < 2; p++) begin
      slv_rsp[p]  = '0;
      gnt_wait[p] = 0;
      head[p]     = 0;
      tail[p]     = 0;
    end
    repeat (10) @(posedge clk_i);
    #5;
    reset_i = 1'b0;
    reset_outputs();
    tcdm_read_after_write();
    tcdm_byte_enable();
    tcdm_contention();
    periph_routing();
    perf_counters();
    mixed_traffic();
    repeat (4) @(posedge clk_i);
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
common/bus_pkg.sv
common/cluster_map_pkg.sv
core_demux/core_demux.sv
core_demux/periph_demux.sv
src/bus_arbiter.sv
src/tcdm_bank.sv
src/cluster_data_path.sv
bench/tb_cluster_data_path.sv

// File: Bender.yml
package:
  name: cluster_data_path

sources:
  - common/bus_pkg.sv
  - common/cluster_map_pkg.sv
  - core_demux/core_demux.sv
  - core_demux/periph_demux.sv
  - src/bus_arbiter.sv
  - src/tcdm_bank.sv
  - src/cluster_data_path.sv
  - target: test
    files:
      - bench/tb_cluster_data_path.sv
